//--- build.f
corevx_pkg.sv
corevx_decode.sv
corevx_regfile.sv
corevx_alu.sv
corevx_exec.sv
corevx_exec_asserts.sv
tb_corevx_exec.sv

//--- corevx_alu.sv
`default_nettype none

module corevx_alu import corevx_pkg::*; (
    input  logic    is_op,
    input  logic    is_op_imm,

    input  shamt_t  shamt,
    input  funct7_t funct7,
    input  funct3_t funct3,

    input  xlen_t   rs1,
    input  xlen_t   rs2,
    input  xlen_t   simm12,

    output xlen_t   result,
    output logic    illegal_instruction
);

    logic f7_base;
    logic f7_alt;
    logic f7_md;

    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);
    assign f7_md   = (funct7 == F7_MULDIV);

    // op-imm forms.
    logic is_addi, is_slti, is_sltiu, is_xori, is_ori, is_andi;
    logic is_slli, is_srli, is_srai, is_shift_imm;

    assign is_addi      = is_op_imm && (funct3 == 3'b000);
    assign is_slti      = is_op_imm && (funct3 == 3'b010);
    assign is_sltiu     = is_op_imm && (funct3 == 3'b011);
    assign is_xori      = is_op_imm && (funct3 == 3'b100);
    assign is_ori       = is_op_imm && (funct3 == 3'b110);
    assign is_andi      = is_op_imm && (funct3 == 3'b111);
    assign is_slli      = is_op_imm && (funct3 == 3'b001) && f7_base;
    assign is_srli      = is_op_imm && (funct3 == 3'b101) && f7_base;
    assign is_srai      = is_op_imm && (funct3 == 3'b101) && f7_alt;
    assign is_shift_imm = is_slli || is_srli || is_srai;

    // op forms, base and alternate.
    logic is_add, is_sub, is_slt, is_sltu, is_xor, is_or, is_and;
    logic is_sll, is_srl, is_sra;

    assign is_add  = is_op && (funct3 == 3'b000) && f7_base;
    assign is_sub  = is_op && (funct3 == 3'b000) && f7_alt;
    assign is_sll  = is_op && (funct3 == 3'b001) && f7_base;
    assign is_slt  = is_op && (funct3 == 3'b010) && f7_base;
    assign is_sltu = is_op && (funct3 == 3'b011) && f7_base;
    assign is_xor  = is_op && (funct3 == 3'b100) && f7_base;
    assign is_srl  = is_op && (funct3 == 3'b101) && f7_base;
    assign is_sra  = is_op && (funct3 == 3'b101) && f7_alt;
    assign is_or   = is_op && (funct3 == 3'b110) && f7_base;
    assign is_and  = is_op && (funct3 == 3'b111) && f7_base;

    // m extension.
    logic is_mul, is_mulh, is_mulhsu, is_mulhu, is_div, is_divu, is_rem, is_remu;

    assign is_mul    = is_op && f7_md && (funct3 == 3'b000);
    assign is_mulh   = is_op && f7_md && (funct3 == 3'b001);
    assign is_mulhsu = is_op && f7_md && (funct3 == 3'b010);
    assign is_mulhu  = is_op && f7_md && (funct3 == 3'b011);
    assign is_div    = is_op && f7_md && (funct3 == 3'b100);
    assign is_divu   = is_op && f7_md && (funct3 == 3'b101);
    assign is_rem    = is_op && f7_md && (funct3 == 3'b110);
    assign is_remu   = is_op && f7_md && (funct3 == 3'b111);

    xlen_t       op2;
    shamt_t      sh_amt;
    logic        lt_s;
    logic        lt_u;
    logic        div_zero;
    logic        div_ovf;
    logic [63:0] prod_ss;
    logic [63:0] prod_su;
    logic [63:0] prod_uu;

    assign op2    = is_op ? rs2 : simm12;
    assign sh_amt = is_shift_imm ? shamt : rs2[4:0];  // only low five bits count.
    assign lt_s   = $signed(rs1) < $signed(op2);
    assign lt_u   = rs1 < op2;

    // extend by hand, low 64 bits of the product are then exact.
    assign prod_ss = {{XLEN{rs1[XLEN-1]}}, rs1} * {{XLEN{rs2[XLEN-1]}}, rs2};
    assign prod_su = {{XLEN{rs1[XLEN-1]}}, rs1} * {{XLEN{1'b0}}, rs2};
    assign prod_uu = {{XLEN{1'b0}}, rs1} * {{XLEN{1'b0}}, rs2};

    assign div_zero = (rs2 == '0);
    assign div_ovf  = (rs1 == 32'h8000_0000) && (rs2 == '1);  // min / -1.

    always_comb begin
        illegal_instruction = 1'b0;
        case (1'b1)
            is_addi, is_add:   result = rs1 + op2;
            is_sub:            result = rs1 - rs2;
            is_slt, is_slti:   result = {{(XLEN-1){1'b0}}, lt_s};
            is_sltu, is_sltiu: result = {{(XLEN-1){1'b0}}, lt_u};
            is_sll, is_slli:   result = rs1 << sh_amt;
            is_srl, is_srli:   result = rs1 >> sh_amt;
            is_sra, is_srai:   result = $signed(rs1) >>> sh_amt;
            is_xor, is_xori:   result = rs1 ^ op2;
            is_or, is_ori:     result = rs1 | op2;
            is_and, is_andi:   result = rs1 & op2;
            is_mul:            result = prod_ss[31:0];
            is_mulh:           result = prod_ss[63:32];
            is_mulhsu:         result = prod_su[63:32];
            is_mulhu:          result = prod_uu[63:32];
            is_div: begin
                if (div_zero)
                    result = '1;
                else if (div_ovf)
                    result = rs1;
                else
                    result = $signed(rs1) / $signed(rs2);
            end
            is_divu:           result = div_zero ? '1 : rs1 / rs2;
            is_rem: begin
                if (div_zero)
                    result = rs1;
                else if (div_ovf)
                    result = '0;
                else
                    result = $signed(rs1) % $signed(rs2);
            end
            is_remu:           result = div_zero ? rs1 : rs1 % rs2;
            default: begin
                illegal_instruction = 1'b1;
                result = rs1 + op2;  // harmless filler value.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- corevx_decode.sv
`default_nettype none

module corevx_decode import corevx_pkg::*; (
    input  instr_t    instr,

    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output funct3_t   funct3,
    output funct7_t   funct7,
    output shamt_t    shamt,
    output xlen_t     simm12,
    output logic      is_op,
    output logic      is_op_imm
);

    opcode_t opcode;

    assign opcode = instr[6:0];

    // register indices sit in the same place for both formats.
    assign rd_addr  = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];  // upper immediate bits on op-imm shifts.
    assign shamt  = instr[24:20];

    // i-type immediate, sign extended to a full word.
    assign simm12 = {{(XLEN-12){instr[31]}}, instr[31:20]};

    // anything else leaves both flags low and ends up illegal in the alu.
    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);

endmodule

`default_nettype wire

//--- corevx_exec.sv
`default_nettype none

module corevx_exec import corevx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      instr_valid,
    input  instr_t    instr,

    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data,
    output logic      wb_illegal
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    funct3_t   funct3;
    funct7_t   funct7;
    shamt_t    shamt;
    xlen_t     simm12;
    logic      is_op;
    logic      is_op_imm;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     alu_result;
    logic      alu_illegal;
    logic      wr_en;

    corevx_decode corevx_decode_inst (
        .instr     (instr),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd_addr   (rd_addr),
        .funct3    (funct3),
        .funct7    (funct7),
        .shamt     (shamt),
        .simm12    (simm12),
        .is_op     (is_op),
        .is_op_imm (is_op_imm)
    );

    // write lands on the same edge as wb_*, so no forwarding needed.
    assign wr_en = instr_valid && !alu_illegal && (rd_addr != '0);

    corevx_regfile corevx_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (rd_addr),
        .wr_data  (alu_result)
    );

    corevx_alu corevx_alu_inst (
        .is_op               (is_op),
        .is_op_imm           (is_op_imm),
        .shamt               (shamt),
        .funct7              (funct7),
        .funct3              (funct3),
        .rs1                 (rs1_data),
        .rs2                 (rs2_data),
        .simm12              (simm12),
        .result              (alu_result),
        .illegal_instruction (alu_illegal)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            wb_illegal <= 1'b0;
            wb_rd      <= '0;
            wb_data    <= '0;
        end else begin
            wb_valid   <= instr_valid;  // one-cycle pulse.
            wb_illegal <= instr_valid && alu_illegal;
            if (instr_valid) begin
                wb_rd   <= rd_addr;
                wb_data <= alu_result;
            end
        end
    end

endmodule

`default_nettype wire

//--- corevx_exec_asserts.sv
`default_nettype none

module corevx_exec_asserts (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic wb_valid,
    input logic wb_illegal
);

    int unsigned fail_count = 0;

    // one-cycle latency, no stalls.
    wb_valid_follows_issue: assert property (
        @(posedge clk) rst_n |=> (wb_valid == $past(instr_valid))
    ) else begin
        $error("wb_valid does not match instr_valid of the previous cycle");
        fail_count++;
    end

    wb_quiet_in_reset: assert property (
        @(posedge clk) !rst_n |=> (!wb_valid && !wb_illegal)
    ) else begin
        $error("write-back strobes active while in reset");
        fail_count++;
    end

    wb_illegal_needs_valid: assert property (
        @(posedge clk) wb_illegal |-> wb_valid
    ) else begin
        $error("wb_illegal high without wb_valid");
        fail_count++;
    end

endmodule

bind corevx_exec corevx_exec_asserts corevx_exec_asserts_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_illegal  (wb_illegal)
);

`default_nettype wire

//--- corevx_pkg.sv
`default_nettype none

package corevx_pkg;

    // datapath widths.
    localparam int XLEN     = 32;
    localparam int ILEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // words and register indices.
    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [ILEN-1:0]   instr_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // instruction fields.
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] shamt_t;

    // major opcodes handled by the execute slice.
    localparam opcode_t OPC_OP     = 7'b0110011;  // register-register.
    localparam opcode_t OPC_OP_IMM = 7'b0010011;  // register-immediate.

    // funct7 encodings.
    localparam funct7_t F7_BASE   = 7'h00;
    localparam funct7_t F7_ALT    = 7'h20;  // sub and sra/srai.
    localparam funct7_t F7_MULDIV = 7'h01;  // M extension.

endpackage

`default_nettype wire

//--- corevx_regfile.sv
`default_nettype none

module corevx_regfile import corevx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,

    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  xlen_t     wr_data
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;  // x0 never written.
        end
    end

    // x0 reads as zero regardless of the array contents.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- tb_corevx_exec.sv
`default_nettype none

module tb_corevx_exec import corevx_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int N_LOAD     = 16 + 70;
    localparam int N_ALU      = 200;
    localparam int N_MUL      = 60;
    localparam int N_DIV      = 60;
    localparam int N_FIXED    = 5 + 6 + 12 + 1 + 4;  // extremes, div corners, illegal, idle, x0.
    localparam int NUM_INSTR  = N_LOAD + N_ALU + N_MUL + N_DIV + N_FIXED;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    instr_t    instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    xlen_t     wb_data;
    logic      wb_illegal;

    xlen_t     shadow [NUM_REGS];
    reg_addr_t exp_rd_q [$];
    xlen_t     exp_data_q [$];
    logic      exp_ill_q [$];

    // funct3 per random op, r-type then i-type.
    funct3_t r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    funct3_t i_f3 [9]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};

    corevx_exec corevx_exec_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_illegal  (wb_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic instr_t enc_r(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3,
                                     reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                     reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic reg_addr_t rand_reg(int lo, int hi);
        return reg_addr_t'(lo + $urandom % (hi - lo + 1));
    endfunction

    // expected write-back from the rv32im rules.
    function automatic void ref_exec(input instr_t ins, input xlen_t a, input xlen_t b,
                                     output xlen_t d, output logic ill);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic signed [63:0] t;
        xlen_t              op2;
        xlen_t              sra_val;
        funct3_t            f3;
        logic               is_imm;
        logic               alt;
        shamt_t             sh;
        sa      = $signed(a);
        sb      = $signed(b);
        ua      = {32'b0, a};
        ub      = {32'b0, b};
        f3      = ins[14:12];
        is_imm  = (ins[6:0] == OPC_OP_IMM);
        alt     = (ins[31:25] == F7_ALT);
        op2     = is_imm || ins[6:0] != OPC_OP ? {{20{ins[31]}}, ins[31:20]} : b;
        sh      = is_imm ? ins[24:20] : b[4:0];
        sra_val = $signed(a) >>> sh;
        ill     = 1'b0;
        d       = '0;
        if (ins[6:0] == OPC_OP && ins[31:25] == F7_MULDIV) begin
            case (f3)
                3'd0:    t = sa * sb;
                3'd1:    t = (sa * sb) >>> 32;
                3'd2:    t = (sa * ub) >>> 32;
                3'd3:    t = (ua * ub) >>> 32;
                3'd4:    t = (b == '0) ? -64'sd1 : sa / sb;  // 64-bit keeps min / -1 exact.
                3'd5:    t = (b == '0) ? -64'sd1 : ua / ub;
                3'd6:    t = (b == '0) ? sa : sa % sb;
                default: t = (b == '0) ? ua : ua % ub;
            endcase
            d = t[31:0];
        end else if (ins[6:0] == OPC_OP || is_imm) begin
            case (f3)
                3'd0:    d = (alt && !is_imm) ? a - b : a + op2;
                3'd1:    d = a << sh;
                3'd2:    d = {31'b0, $signed(a) < $signed(op2)};
                3'd3:    d = {31'b0, a < op2};
                3'd4:    d = a ^ op2;
                3'd5:    d = alt ? sra_val : a >> sh;
                3'd6:    d = a | op2;
                default: d = a & op2;
            endcase
            if (is_imm)
                ill = (f3 == 3'd1 || f3 == 3'd5) && ins[31:25] != F7_BASE
                      && !(f3 == 3'd5 && alt);
            else
                ill = !(ins[31:25] == F7_BASE || (alt && (f3 == 3'd0 || f3 == 3'd5)));
        end else begin
            ill = 1'b1;
        end
        if (ill)
            d = a + op2;
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // shadow file is updated in issue order, same as the dut.
    task automatic issue(input instr_t ins);
        xlen_t d;
        logic  ill;
        ref_exec(ins, shadow[ins[19:15]], shadow[ins[24:20]], d, ill);
        if (!ill && ins[11:7] != '0)
            shadow[ins[11:7]] = d;
        exp_rd_q.push_back(ins[11:7]);
        exp_data_q.push_back(d);
        exp_ill_q.push_back(ill);
        instr_valid <= 1'b1;
        instr       <= ins;
        @(posedge clk);
    endtask

    task automatic load_regs();
        // or of register pairs into x0, zero only if reset cleared both.
        for (int i = 1; i < NUM_REGS; i += 2)
            issue(enc_r(F7_BASE, reg_addr_t'((i + 1) % NUM_REGS), reg_addr_t'(i), 3'd6, 5'd0));
        for (int i = 1; i < NUM_REGS; i++)
            issue(enc_i(12'($urandom), 5'd0, 3'd0, reg_addr_t'(i)));
        // top down, so the first read hits the register just written.
        for (int i = NUM_REGS - 1; i > 0; i--)
            issue(enc_r(F7_BASE, 5'd0, reg_addr_t'(i), 3'd0, reg_addr_t'(i)));
        for (int i = 1; i <= 8; i++)
            issue(enc_i(12'($urandom), reg_addr_t'(i), 3'd0, reg_addr_t'(i + 1)));
    endtask

    task automatic alu_random();
        int        k;
        reg_addr_t rd;
        reg_addr_t rs1;
        repeat (N_ALU) begin
            k   = $urandom % 19;
            rd  = rand_reg(0, 31);
            rs1 = rand_reg(0, 31);
            if (k < 10)
                issue(enc_r((k == 1 || k == 7) ? F7_ALT : F7_BASE, rand_reg(0, 31), rs1,
                            r_f3[k], rd));
            else if (k < 16)
                issue(enc_i(12'($urandom), rs1, i_f3[k - 10], rd));
            else
                issue(enc_i({(k == 18) ? F7_ALT : F7_BASE, 5'($urandom)}, rs1, i_f3[k - 10], rd));
        end
    endtask

    // x28..x31 hold the extremes; results go to x1..x27.
    task automatic muldiv_tests();
        issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd31));
        issue(enc_i(12'h001, 5'd0, 3'd0, 5'd30));
        issue(enc_i({F7_BASE, 5'd31}, 5'd30, 3'd1, 5'd30));  // most negative.
        issue(enc_i({F7_BASE, 5'd1}, 5'd31, 3'd5, 5'd29));   // most positive.
        issue(enc_r(F7_BASE, 5'd0, 5'd0, 3'd0, 5'd28));
        repeat (N_MUL)
            issue(enc_r(F7_MULDIV, rand_reg(0, 31), rand_reg(0, 31), 3'($urandom % 4),
                        rand_reg(1, 27)));
        issue(enc_r(F7_MULDIV, 5'd31, 5'd30, 3'd4, rand_reg(1, 27)));  // min / -1.
        issue(enc_r(F7_MULDIV, 5'd31, 5'd30, 3'd6, rand_reg(1, 27)));
        issue(enc_r(F7_MULDIV, 5'd28, 5'd29, 3'd4, rand_reg(1, 27)));  // divide by zero.
        issue(enc_r(F7_MULDIV, 5'd0, 5'd30, 3'd5, rand_reg(1, 27)));
        issue(enc_r(F7_MULDIV, 5'd28, 5'd29, 3'd6, rand_reg(1, 27)));
        issue(enc_r(F7_MULDIV, 5'd0, 5'd31, 3'd7, rand_reg(1, 27)));
        repeat (N_DIV)
            issue(enc_r(F7_MULDIV, rand_reg(0, 31), rand_reg(0, 31), 3'(4 + $urandom % 4),
                        rand_reg(1, 27)));
    endtask

    task automatic illegal_tests();
        instr_t    ins;
        reg_addr_t rd;
        for (int i = 0; i < 6; i++) begin
            rd = rand_reg(1, 31);
            case (i)
                0:       ins = enc_r(7'h02, 5'd3, 5'd4, 3'd0, rd);
                1:       ins = enc_r(F7_ALT, 5'd5, 5'd6, 3'd7, rd);
                2:       ins = enc_i({F7_ALT, 5'd3}, 5'd7, 3'd1, rd);  // slli, bad funct7.
                3:       ins = enc_i({F7_MULDIV, 5'd9}, 5'd8, 3'd5, rd);
                4:       ins = {20'($urandom), rd, 7'b0110111};
                default: ins = {12'($urandom), 5'd9, 3'd2, rd, 7'b0000011};
            endcase
            issue(ins);
            issue(enc_r(F7_BASE, 5'd0, rd, 3'd0, rd));  // read back, must be unchanged.
        end
    endtask

    // a live encoding on the bus without instr_valid must not write.
    task automatic idle_test();
        instr_valid <= 1'b0;
        instr       <= enc_i(12'h001, 5'd5, 3'd0, 5'd5);
        repeat (2) @(posedge clk);
        issue(enc_r(F7_BASE, 5'd0, 5'd5, 3'd0, 5'd5));
    endtask

    task automatic zero_reg_tests();
        issue(enc_i(12'h07b, 5'd3, 3'd0, 5'd0));
        issue(enc_r(F7_BASE, 5'd2, 5'd1, 3'd0, 5'd0));
        issue(enc_r(F7_BASE, 5'd0, 5'd0, 3'd0, 5'd9));
        issue(enc_i(12'hfff, 5'd0, 3'd6, 5'd10));
    endtask

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("wb_valid pulsed with no instruction outstanding");
                abort_run();
            end else begin
                check_reg("wb_rd", wb_rd, exp_rd_q.pop_front());
                check_word("wb_data", wb_data, exp_data_q.pop_front());
                check_bit("wb_illegal", wb_illegal, exp_ill_q.pop_front());
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_INSTR + 20));
        $display("timeout, run did not finish within %0d cycles", NUM_INSTR + 20);
        abort_run();
    end

    initial begin
        void'($urandom(32'hdd77));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        foreach (shadow[i])
            shadow[i] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("wb_valid", wb_valid, 1'b0);  // write-back register after reset.
        check_bit("wb_illegal", wb_illegal, 1'b0);
        check_reg("wb_rd", wb_rd, '0);
        check_word("wb_data", wb_data, '0);
        @(posedge clk);
        load_regs();
        alu_random();
        muldiv_tests();
        illegal_tests();
        idle_test();
        zero_reg_tests();
        instr_valid <= 1'b0;
        repeat (3) @(posedge clk);
        if (exp_rd_q.size() != 0) begin
            $display("%0d results never came back", exp_rd_q.size());
            abort_run();
        end else if (corevx_exec_inst.corevx_exec_asserts_inst.fail_count != 0) begin
            $display("write-back assertions failed during the run");
            abort_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
